// ==== logic/riscv_isa_pkg.sv ====
// ------------------------------------------------
// RV32I instruction-set definitions for the
// register-access slice: widths, opcode and funct
// encodings, and the I-type immediate extraction.
// Import wherever instruction fields are decoded.
// ------------------------------------------------
package riscv_isa_pkg;

    // register file geometry
    localparam int REG_ADDR_W = 5;
    localparam int REG_DATA_W = 32;
    localparam int REG_NUM    = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;
    typedef logic [31:0]           instr_t;

    // x0, reads as zero on a hardwired file
    localparam reg_addr_t ZERO_REG = '0;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // funct3, ADDI shares the ADD/SUB code
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;

    // funct7, only SUB sets bit 30
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // I-type immediate, sign extended from bit 31
    function automatic reg_data_t imm_i(input instr_t instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

endpackage

// ==== logic/core_bus_pkg.sv ====
// ------------------------------------------------
// Bundles passed between decode, execute and the
// jump-target block. Field types come from the
// ISA package so widths follow the register file.
// ------------------------------------------------
package core_bus_pkg;

    // ALU function selected by decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // decode to execute, b already muxed with the immediate
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::reg_data_t a;
        riscv_isa_pkg::reg_data_t b;
    } issue_t;

    // write-back report, x0 writes included
    typedef struct packed {
        logic                     valid;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::reg_data_t data;
    } wb_t;

    // JALR request, imm already sign extended
    typedef struct packed {
        logic                     valid;
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_data_t imm;
    } bpu_req_t;

    typedef struct packed {
        logic                     valid;
        riscv_isa_pkg::reg_data_t target;
    } bpu_pred_t;

endpackage

// ==== logic/gpr.sv ====
// ------------------------------------------------
// General-purpose register file, 32 x 32 bits.
// One write port from execute, read ports 1 and 2
// for decode and port 3 for the jump-target block.
// Reads see a same-cycle write through a bypass.
// ------------------------------------------------
`timescale 1ns/1ps

module gpr #(
    // 1: x0 reads zero and ignores writes
    parameter bit ZERO_REG_HARDWIRED = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset_i,

    // write port, driven by execute
    input  logic                     we_i,
    input  riscv_isa_pkg::reg_addr_t waddr_i,
    input  riscv_isa_pkg::reg_data_t wdata_i,

    // decode operand ports
    input  riscv_isa_pkg::reg_addr_t raddr1_i,
    input  riscv_isa_pkg::reg_addr_t raddr2_i,
    // jump-target port
    input  riscv_isa_pkg::reg_addr_t raddr3_i,

    output riscv_isa_pkg::reg_data_t rdata1_o,
    output riscv_isa_pkg::reg_data_t rdata2_o,
    output riscv_isa_pkg::reg_data_t rdata3_o
);

    import riscv_isa_pkg::*;

    reg_data_t regs_q [REG_NUM];
    logic      wr_en;

    // write qualified, x0 blocked when hardwired
    assign wr_en = we_i && !(ZERO_REG_HARDWIRED && (waddr_i == ZERO_REG));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 first, then bypass of the active write, then storage
    function automatic reg_data_t read_port(input reg_addr_t addr);
        reg_data_t val;
        if (ZERO_REG_HARDWIRED && (addr == ZERO_REG)) begin
            val = '0;
        end else if (wr_en && (addr == waddr_i)) begin
            val = wdata_i;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    // same lookup on all three ports
    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
        rdata3_o = read_port(raddr3_i);
    end

endmodule

// ==== logic/id_stage.sv ====
// ------------------------------------------------
// Decode stage. Four-phase req/ack slave towards
// the issuer, decodes one RV32I instruction, reads
// rs1/rs2 and loads a one-cycle issue to execute
// or a one-cycle request to the jump-target block.
// Unsupported opcodes are acked and dropped.
// ------------------------------------------------
`timescale 1ns/1ps

module id_stage (
    input  logic                     clk,
    input  logic                     reset_i,

    // issuer handshake
    input  logic                     req_i,
    input  riscv_isa_pkg::instr_t    instr_i,
    output logic                     ack_o,

    // register file ports 1 and 2
    output riscv_isa_pkg::reg_addr_t raddr1_o,
    output riscv_isa_pkg::reg_addr_t raddr2_o,
    input  riscv_isa_pkg::reg_data_t rdata1_i,
    input  riscv_isa_pkg::reg_data_t rdata2_i,

    output core_bus_pkg::issue_t     issue_o,
    output core_bus_pkg::bpu_req_t   bpu_req_o
);

    import riscv_isa_pkg::*;
    import core_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        RELEASE
    } hs_state_e;

    hs_state_e state_q;
    logic      capture;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_data_t  imm;

    alu_op_e    alu_op;
    logic       alu_ok;
    logic       use_imm;
    logic       is_jalr;

    issue_t     issue_q;
    bpu_req_t   bpu_req_q;

    // instruction fields
    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign imm    = imm_i(instr_i);

    // operands looked up straight from the held instruction
    assign raddr1_o = instr_i[19:15];
    assign raddr2_o = instr_i[24:20];

    // take the instruction on the first idle cycle with req high
    assign capture = (state_q == IDLE) && req_i;

    // ack held through ACKED and RELEASE
    assign ack_o = (state_q != IDLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (req_i) state_q <= ACKED;
                // wait for the issuer to drop req
                ACKED:   if (!req_i) state_q <= RELEASE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // opcode/funct to ALU function
    always_comb begin
        alu_op  = ALU_ADD;
        alu_ok  = 1'b0;
        use_imm = 1'b0;
        is_jalr = 1'b0;
        case (opcode)
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                        alu_ok = (funct7 == F7_SUB) || (funct7 == F7_BASE);
                    end
                    F3_XOR: begin
                        alu_op = ALU_XOR;
                        alu_ok = (funct7 == F7_BASE);
                    end
                    F3_OR: begin
                        alu_op = ALU_OR;
                        alu_ok = (funct7 == F7_BASE);
                    end
                    F3_AND: begin
                        alu_op = ALU_AND;
                        alu_ok = (funct7 == F7_BASE);
                    end
                    default: alu_ok = 1'b0;
                endcase
            end
            // ADDI only, other OP-IMM codes dropped
            OPC_OP_IMM: begin
                alu_ok  = (funct3 == F3_ADD_SUB);
                use_imm = 1'b1;
            end
            OPC_JALR: is_jalr = (funct3 == F3_JALR);
            default:  alu_ok = 1'b0;
        endcase
    end

    // valids pulse for the single cycle after capture
    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue_q   <= '0;
            bpu_req_q <= '0;
        end else begin
            issue_q.valid   <= capture && alu_ok;
            bpu_req_q.valid <= capture && is_jalr;
            if (capture) begin
                issue_q.op    <= alu_op;
                issue_q.rd    <= instr_i[11:7];
                issue_q.a     <= rdata1_i;
                issue_q.b     <= use_imm ? imm : rdata2_i;
                bpu_req_q.rs1 <= instr_i[19:15];
                bpu_req_q.imm <= imm;
            end
        end
    end

    assign issue_o   = issue_q;
    assign bpu_req_o = bpu_req_q;

endmodule

// ==== logic/ex_stage.sv ====
// ------------------------------------------------
// Execute stage. Single-cycle ALU for ADD, SUB,
// AND, OR and XOR on the issued operands; drives
// the register file write port in the same cycle
// and reports every write on wb_o.
// ------------------------------------------------
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,
    input  logic                     reset_i,

    input  core_bus_pkg::issue_t     issue_i,

    // register file write port
    output logic                     we_o,
    output riscv_isa_pkg::reg_addr_t waddr_o,
    output riscv_isa_pkg::reg_data_t wdata_o,

    output core_bus_pkg::wb_t        wb_o
);

    import riscv_isa_pkg::*;
    import core_bus_pkg::*;

    reg_data_t result;

    // ALU, SUB wraps modulo 2^32
    always_comb begin
        case (issue_i.op)
            ALU_ADD: result = issue_i.a + issue_i.b;
            ALU_SUB: result = issue_i.a - issue_i.b;
            ALU_AND: result = issue_i.a & issue_i.b;
            ALU_OR:  result = issue_i.a | issue_i.b;
            ALU_XOR: result = issue_i.a ^ issue_i.b;
            default: result = '0;
        endcase
    end

    // write goes out combinationally, stored at the next edge
    assign we_o    = issue_i.valid;
    assign waddr_o = issue_i.rd;
    assign wdata_o = result;

    // report mirrors the write port
    // x0 writes are reported even though the file drops them
    always_comb begin
        wb_o.valid = issue_i.valid;
        wb_o.rd    = issue_i.rd;
        wb_o.data  = result;
    end

endmodule

// ==== logic/bpu.sv ====
// ------------------------------------------------
// Jump-target prediction for JALR. Reads rs1 on
// register file port 3 in the cycle the request
// is valid and presents rs1 + imm with bit 0
// cleared, valid for that one cycle.
// ------------------------------------------------
`timescale 1ns/1ps

module bpu (
    input  logic                     clk,
    input  logic                     reset_i,

    // registered JALR request from decode
    input  core_bus_pkg::bpu_req_t   req_i,

    // register file port 3
    output riscv_isa_pkg::reg_addr_t raddr3_o,
    input  riscv_isa_pkg::reg_data_t rdata3_i,

    output core_bus_pkg::bpu_pred_t  pred_o
);

    import riscv_isa_pkg::*;

    reg_data_t sum;

    // base register straight from the request
    assign raddr3_o = req_i.rs1;

    assign sum = rdata3_i + req_i.imm;

    // JALR target, lsb forced low
    always_comb begin
        pred_o.valid  = req_i.valid;
        pred_o.target = {sum[REG_DATA_W-1:1], 1'b0};
    end

endmodule

// ==== logic/exec_core_top.sv ====
// ------------------------------------------------
// Register-access slice of the RV32I core. Ties
// decode, execute, jump-target block and register
// file together. Issuer talks four-phase req/ack;
// write-back and JALR prediction are reported out.
// ------------------------------------------------
`timescale 1ns/1ps

module exec_core_top #(
    // forwarded to the register file
    parameter bit ZERO_REG_HARDWIRED = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    req_i,
    input  riscv_isa_pkg::instr_t   instr_i,
    output logic                    ack_o,

    output core_bus_pkg::wb_t       wb_o,
    output core_bus_pkg::bpu_pred_t pred_o
);

    import riscv_isa_pkg::*;
    import core_bus_pkg::*;

    // decode <-> register file
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    reg_data_t rdata1;
    reg_data_t rdata2;

    // jump-target <-> register file
    reg_addr_t raddr3;
    reg_data_t rdata3;

    // execute -> register file
    logic      we;
    reg_addr_t waddr;
    reg_data_t wdata;

    issue_t    issue;
    bpu_req_t  bpu_req;

    id_stage u_id_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .instr_i   (instr_i),
        .ack_o     (ack_o),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .issue_o   (issue),
        .bpu_req_o (bpu_req)
    );

    ex_stage u_ex_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue),
        .we_o    (we),
        .waddr_o (waddr),
        .wdata_o (wdata),
        .wb_o    (wb_o)
    );

    bpu u_bpu (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (bpu_req),
        .raddr3_o (raddr3),
        .rdata3_i (rdata3),
        .pred_o   (pred_o)
    );

    gpr #(
        .ZERO_REG_HARDWIRED (ZERO_REG_HARDWIRED)
    ) u_gpr (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (we),
        .waddr_i  (waddr),
        .wdata_i  (wdata),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .raddr3_i (raddr3),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .rdata3_o (rdata3)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
// ------------------------------------------------
// Testbench clock and reset source. Free-running
// clock of PERIOD_NS, synchronous reset held high
// for RESET_CYCLES rising edges, released on a
// falling edge.
// ------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== dv/exec_core_sva.sv ====
// ------------------------------------------------
// Concurrent checks for the register-access slice.
// Bound into id_stage for the req/ack rules and
// into gpr for x0 reads and single-cycle writes.
// Inputs a bind site does not own are tied off.
// ------------------------------------------------
`timescale 1ns/1ps

module exec_core_sva (
    input logic                     clk,
    input logic                     reset_i,
    // handshake, observed at id_stage
    input logic                     req_i,
    input logic                     ack_i,
    // register file ports, observed at gpr
    input logic                     we_i,
    input riscv_isa_pkg::reg_addr_t raddr1_i,
    input riscv_isa_pkg::reg_addr_t raddr2_i,
    input riscv_isa_pkg::reg_addr_t raddr3_i,
    input riscv_isa_pkg::reg_data_t rdata1_i,
    input riscv_isa_pkg::reg_data_t rdata2_i,
    input riscv_isa_pkg::reg_data_t rdata3_i
);

    // read back by the testbench at the end of the run
    int fail_cnt = 0;

    // ack only rises on a cycle that sampled req high
    ack_rise_on_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose without a pending req");
            fail_cnt++;
        end

    // ack only falls once req was seen low
    ack_fall_after_req: assert property (@(posedge clk) disable iff (reset_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            $error("ack fell while req was still high");
            fail_cnt++;
        end

    // x0 reads zero on every port
    x0_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
        ((raddr1_i == '0) |-> (rdata1_i == '0)) and
        ((raddr2_i == '0) |-> (rdata2_i == '0)) and
        ((raddr3_i == '0) |-> (rdata3_i == '0)))
        else begin
            $error("x0 returned a nonzero value");
            fail_cnt++;
        end

    // write port mirrors wb_o.valid, one cycle per issue
    wb_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        we_i |=> !we_i)
        else begin
            $error("write-back valid held for more than one cycle");
            fail_cnt++;
        end

endmodule

bind id_stage exec_core_sva u_hs_sva (
    .clk      (clk),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .we_i     (1'b0),
    .raddr1_i ('0),
    .raddr2_i ('0),
    .raddr3_i ('0),
    .rdata1_i ('0),
    .rdata2_i ('0),
    .rdata3_i ('0)
);

bind gpr exec_core_sva u_rf_sva (
    .clk      (clk),
    .reset_i  (reset_i),
    .req_i    (1'b0),
    .ack_i    (1'b0),
    .we_i     (we_i),
    .raddr1_i (raddr1_i),
    .raddr2_i (raddr2_i),
    .raddr3_i (raddr3_i),
    .rdata1_i (rdata1_o),
    .rdata2_i (rdata2_o),
    .rdata3_i (rdata3_o)
);

// ==== dv/exec_core_tb.sv ====
// ------------------------------------------------
// Directed testbench for exec_core_top. Issues one
// instruction per four-phase exchange, keeps a
// reference register model and checks write-back
// and JALR prediction against it. Inputs change on
// the falling edge, outputs are sampled there too.
// ------------------------------------------------
`timescale 1ns/1ps

module exec_core_tb;

    import riscv_isa_pkg::*;
    import core_bus_pkg::*;

    // about 100 issues of 4 cycles each, limit near four times that plus reset
    localparam int MAX_CYCLES = 2000;
    localparam int N_RAND_OPS = 40;

    logic      clk;
    logic      reset;
    logic      req;
    instr_t    instr;
    logic      ack;
    wb_t       wb;
    bpu_pred_t pred;

    reg_data_t model [REG_NUM];
    int        cycle_cnt;
    integer    seed;

    tb_clk_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    exec_core_top #(
        .ZERO_REG_HARDWIRED (1'b1)
    ) dut_i (
        .clk     (clk),
        .reset_i (reset),
        .req_i   (req),
        .instr_i (instr),
        .ack_o   (ack),
        .wb_o    (wb),
        .pred_o  (pred)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // watchdog
    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout, the DUT stopped answering the handshake");
        $display("Test FAILED");
        $fatal(1, "cycle limit reached");
    end

    task automatic check(input string test, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // non-negative random value below n
    task automatic rand_below(input int n, output int v);
        v = $random(seed);
        v = (v & 32'h7fff_ffff) % n;
    endtask

    function automatic reg_data_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // x0 never changes
    function automatic void write_model(input reg_addr_t rd, input reg_data_t val);
        if (rd != 5'd0) begin
            model[rd] = val;
        end
    endfunction

    // full four-phase exchange, reports taken in the cycle after capture
    task automatic issue(input instr_t word, output wb_t wb_seen, output bpu_pred_t pred_seen);
        @(negedge clk);
        instr = word;
        req   = 1'b1;
        do begin
            @(negedge clk);
        end while (!ack);
        wb_seen   = wb;
        pred_seen = pred;
        req       = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
    endtask

    task automatic do_rtype(input string test, input logic [6:0] f7, input logic [2:0] f3,
                            input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        reg_data_t a;
        reg_data_t b;
        reg_data_t exp_val;
        wb_t       wb_seen;
        bpu_pred_t pred_seen;
        a = model[rs1];
        b = model[rs2];
        case (f3)
            F3_XOR:  exp_val = a ^ b;
            F3_OR:   exp_val = a | b;
            F3_AND:  exp_val = a & b;
            default: exp_val = (f7 == F7_SUB) ? a - b : a + b;
        endcase
        issue({f7, rs2, rs1, f3, rd, OPC_OP}, wb_seen, pred_seen);
        check(test, "wb valid", 32'd1, wb_seen.valid);
        check(test, "wb rd", rd, wb_seen.rd);
        check(test, "wb data", exp_val, wb_seen.data);
        check(test, "pred valid", 32'd0, pred_seen.valid);
        write_model(rd, exp_val);
    endtask

    task automatic do_addi(input string test, input reg_addr_t rd, input reg_addr_t rs1,
                           input logic [11:0] imm);
        reg_data_t exp_val;
        wb_t       wb_seen;
        bpu_pred_t pred_seen;
        exp_val = model[rs1] + sext12(imm);
        issue({imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM}, wb_seen, pred_seen);
        check(test, "wb valid", 32'd1, wb_seen.valid);
        check(test, "wb rd", rd, wb_seen.rd);
        check(test, "wb data", exp_val, wb_seen.data);
        write_model(rd, exp_val);
    endtask

    // link register x1 is named but must stay untouched
    task automatic do_jalr(input string test, input reg_addr_t rs1, input logic [11:0] imm);
        reg_data_t exp_target;
        wb_t       wb_seen;
        bpu_pred_t pred_seen;
        exp_target = (model[rs1] + sext12(imm)) & ~32'd1;
        issue({imm, rs1, F3_JALR, 5'd1, OPC_JALR}, wb_seen, pred_seen);
        check(test, "pred valid", 32'd1, pred_seen.valid);
        check(test, "pred target", exp_target, pred_seen.target);
        check(test, "wb valid", 32'd0, wb_seen.valid);
    endtask

    task automatic test_reset();
        wait (!reset);
        @(negedge clk);
        check("reset", "ack", 32'd0, ack);
        check("reset", "wb valid", 32'd0, wb.valid);
        check("reset", "pred valid", 32'd0, pred.valid);
        // every register reads back zero
        for (int r = 1; r < REG_NUM; r++) begin
            do_rtype("reset", F7_BASE, F3_OR, reg_addr_t'(r), reg_addr_t'(r), 5'd0);
        end
    endtask

    task automatic test_addi_chain();
        do_addi("addi_chain", 5'd1, 5'd0, 12'd5);
        do_addi("addi_chain", 5'd2, 5'd1, 12'hffd);
        do_addi("addi_chain", 5'd3, 5'd2, 12'h7ff);
        do_addi("addi_chain", 5'd4, 5'd3, 12'h800);
        do_addi("addi_chain", 5'd5, 5'd0, 12'h0a5);
        do_addi("addi_chain", 5'd6, 5'd5, 12'hfff);
        do_addi("addi_chain", 5'd7, 5'd6, 12'h123);
        do_addi("addi_chain", 5'd8, 5'd4, 12'd0);
    endtask

    task automatic test_alu_random();
        int         pick;
        int         rd;
        int         rs1;
        int         rs2;
        logic [6:0] f7;
        logic [2:0] f3;
        wb_t        wb_seen;
        bpu_pred_t  pred_seen;
        // spread values into x10..x17
        for (int r = 10; r < 18; r++) begin
            rand_below(4096, pick);
            do_addi("alu_random", reg_addr_t'(r), reg_addr_t'(r - 9), pick[11:0]);
        end
        for (int n = 0; n < N_RAND_OPS; n++) begin
            rand_below(5, pick);
            rand_below(17, rd);
            rand_below(18, rs1);
            rand_below(18, rs2);
            f7 = F7_BASE;
            case (pick)
                0: f3 = F3_ADD_SUB;
                1: begin
                    f3 = F3_ADD_SUB;
                    f7 = F7_SUB;
                end
                2: f3 = F3_AND;
                3: f3 = F3_OR;
                default: f3 = F3_XOR;
            endcase
            do_rtype("alu_random", f7, f3, reg_addr_t'(rd + 1), reg_addr_t'(rs1),
                     reg_addr_t'(rs2));
        end
        // small minus large wraps around
        do_addi("sub_wrap", 5'd18, 5'd0, 12'd5);
        do_addi("sub_wrap", 5'd19, 5'd0, 12'd100);
        do_rtype("sub_wrap", F7_SUB, F3_ADD_SUB, 5'd20, 5'd18, 5'd19);
        // read x20 back, 5 - 100 modulo 2^32
        issue({F7_BASE, 5'd0, 5'd20, F3_OR, 5'd20, OPC_OP}, wb_seen, pred_seen);
        check("sub_wrap", "wb data", 32'hffff_ffa1, wb_seen.data);
    endtask

    task automatic test_x0_writes();
        do_addi("x0_write", 5'd0, 5'd0, 12'h123);
        do_rtype("x0_write", F7_BASE, F3_ADD_SUB, 5'd0, 5'd5, 5'd6);
        // x0 still zero, other operand passes through
        do_rtype("x0_read", F7_BASE, F3_ADD_SUB, 5'd21, 5'd0, 5'd3);
        do_rtype("x0_read", F7_BASE, F3_ADD_SUB, 5'd22, 5'd4, 5'd0);
    endtask

    task automatic test_jalr();
        int rs1;
        int imm;
        for (int n = 0; n < 8; n++) begin
            rand_below(22, rs1);
            rand_below(4096, imm);
            do_jalr("jalr_random", reg_addr_t'(rs1), imm[11:0]);
        end
        // odd sum and negative immediates
        do_addi("jalr_fixed", 5'd23, 5'd0, 12'd7);
        do_jalr("jalr_fixed", 5'd23, 12'hffe);
        do_jalr("jalr_fixed", 5'd23, 12'h800);
        do_jalr("jalr_fixed", 5'd23, 12'd0);
        // no link write-back
        do_rtype("jalr_link", F7_BASE, F3_OR, 5'd24, 5'd1, 5'd0);
    endtask

    task automatic test_dep_and_unsupported();
        wb_t       wb_seen;
        bpu_pred_t pred_seen;
        instr_t    bad_words [4];
        do_addi("back_to_back", 5'd25, 5'd3, 12'd9);
        do_rtype("back_to_back", F7_BASE, F3_ADD_SUB, 5'd26, 5'd25, 5'd25);
        // load, LUI, SLLI and a funct7 outside the kept set
        bad_words[0] = {12'h004, 5'd2, 3'b010, 5'd1, 7'b0000011};
        bad_words[1] = {20'habcde, 5'd1, 7'b0110111};
        bad_words[2] = {7'b0000000, 5'd3, 5'd2, 3'b001, 5'd1, OPC_OP_IMM};
        bad_words[3] = {7'b0000001, 5'd3, 5'd2, F3_ADD_SUB, 5'd1, OPC_OP};
        for (int n = 0; n < 4; n++) begin
            issue(bad_words[n], wb_seen, pred_seen);
            check("unsupported", "wb valid", 32'd0, wb_seen.valid);
            check("unsupported", "pred valid", 32'd0, pred_seen.valid);
        end
        do_rtype("unsupported", F7_BASE, F3_OR, 5'd27, 5'd1, 5'd0);
    endtask

    initial begin
        int sva_fails;
        req       = 1'b0;
        instr     = '0;
        cycle_cnt = 0;
        seed      = 59228;
        for (int r = 0; r < REG_NUM; r++) begin
            model[r] = '0;
        end

        test_reset();
        test_addi_chain();
        test_alu_random();
        test_x0_writes();
        test_jalr();
        test_dep_and_unsupported();

        repeat (2) @(negedge clk);
        sva_fails = dut_i.u_id_stage.u_hs_sva.fail_cnt + dut_i.u_gpr.u_rf_sva.fail_cnt;
        if (sva_fails == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d bound assertion failures during the run", sva_fails);
            $display("Test FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== flist.f ====
logic/riscv_isa_pkg.sv
logic/core_bus_pkg.sv
logic/gpr.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/bpu.sv
logic/exec_core_top.sv
dv/tb_clk_gen.sv
dv/exec_core_sva.sv
dv/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  # packages first, then leaf blocks, then the top level
  - logic/riscv_isa_pkg.sv
  - logic/core_bus_pkg.sv
  - logic/gpr.sv
  - logic/id_stage.sv
  - logic/ex_stage.sv
  - logic/bpu.sv
  - logic/exec_core_top.sv

  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/exec_core_sva.sv
      - dv/exec_core_tb.sv
